/* include/int_pipe_cfg.svh */
/*
 * Build-time configuration macros for the integer pipeline slice
 */
`ifndef INT_PIPE_CFG_SVH
`define INT_PIPE_CFG_SVH

// Operand and result width
`define INT_PIPE_XLEN 32

// Register count, index width follows from it
`define INT_PIPE_NREGS 16

// Cycles a multiply occupies execute
// Any value of 2 or more works
`define INT_PIPE_MUL_CYCLES 3

`endif

/* hw/isa_pkg.sv */
/*
 * ISA types: opcode encoding, register index and the packed instruction word
 */
`default_nettype none

`include "int_pipe_cfg.svh"

package isa_pkg;

	// Register index width
	localparam int REG_IDX_W = $clog2(`INT_PIPE_NREGS);

	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// Opcodes, all single-result register writes
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_AND = 3'd2,
		OP_OR  = 3'd3,
		OP_XOR = 3'd4,
		OP_SLL = 3'd5,
		OP_SRL = 3'd6,
		OP_MUL = 3'd7
	} op_t;

	// Instruction word, opcode in the top bits
	typedef struct packed {
		op_t         op;
		logic        use_imm;  // Immediate replaces rb as operand B
		reg_idx_t    rd;
		reg_idx_t    ra;
		reg_idx_t    rb;
		logic [15:0] imm;      // Signed, extended in decode
	} instr_t;

endpackage

`default_nettype wire

/* hw/pipe_pkg.sv */
/*
 * Pipeline types: operand source select, execute control,
 * in-flight result tag and retire bundle
 */
`default_nettype none

`include "int_pipe_cfg.svh"

package pipe_pkg;

	// Operand source, encoding as in the classic operand mux
	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} opsel_t;

	// Decode to execute control
	typedef struct packed {
		logic               valid;
		isa_pkg::op_t       op;
		isa_pkg::reg_idx_t  rd;
	} ex_ctrl_t;

	// Destination of a result still in flight
	// Also serves as the register file write enable and address
	typedef struct packed {
		logic               valid;
		isa_pkg::reg_idx_t  rd;
	} fwd_tag_t;

	// Retiring result
	typedef struct packed {
		isa_pkg::reg_idx_t          rd;
		logic [`INT_PIPE_XLEN-1:0]  data;
	} retire_t;

endpackage

`default_nettype wire

/* hw/reg_file.sv */
/*
 * Register file with two combinational reads and one write port
 */
`timescale 1ns/1ps
`default_nettype none

`include "int_pipe_cfg.svh"

module reg_file (
	input  wire                          clk,
	input  wire                          rst_n,
	// Read ports
	input  wire isa_pkg::reg_idx_t       ra_addr,
	input  wire isa_pkg::reg_idx_t       rb_addr,
	output logic [`INT_PIPE_XLEN-1:0]    rf_a,
	output logic [`INT_PIPE_XLEN-1:0]    rf_b,
	// Write port from writeback
	input  wire pipe_pkg::fwd_tag_t      wr_tag,
	input  wire [`INT_PIPE_XLEN-1:0]     wr_data
);

	// Register storage as flops
	logic [`INT_PIPE_XLEN-1:0] regs [`INT_PIPE_NREGS];

	//////////////////////////////////////////////////
	// Write
	//////////////////////////////////////////////////

	// Architectural state starts at zero
	// r0 is never written, so it keeps its reset value
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `INT_PIPE_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_tag.valid && (wr_tag.rd != '0)) begin
			regs[wr_tag.rd] <= wr_data;
		end
	end

	//////////////////////////////////////////////////
	// Read
	//////////////////////////////////////////////////

	// No bypass here
	// Writeback writes at the end of its cycle, decode forwards the rest
	assign rf_a = regs[ra_addr];
	assign rf_b = regs[rb_addr];

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
/*
 * Decode stage: instruction latch, immediate sign extension,
 * forwarding source choice and the decode-to-execute control register
 */
`timescale 1ns/1ps
`default_nettype none

`include "int_pipe_cfg.svh"

module decode_stage (
	input  wire                          clk,
	input  wire                          rst_n,
	// Instruction input
	input  wire isa_pkg::instr_t         instr,
	input  wire                          instr_valid,
	output logic                         instr_ready,
	// Stall from the multiplier
	input  wire                          freeze,
	// In-flight results
	input  wire pipe_pkg::fwd_tag_t      ex_tag,
	input  wire pipe_pkg::fwd_tag_t      wb_tag,
	// Register file read addresses
	output isa_pkg::reg_idx_t            ra_addr,
	output isa_pkg::reg_idx_t            rb_addr,
	// Operand mux controls
	output logic [`INT_PIPE_XLEN-1:0]    simm,
	output pipe_pkg::opsel_t             a_sel,
	output pipe_pkg::opsel_t             b_sel,
	// Control into execute
	output pipe_pkg::ex_ctrl_t           ex_ctrl
);

	import isa_pkg::*;
	import pipe_pkg::*;

	// Instruction held in decode
	instr_t dec_instr;
	logic   dec_valid;

	// Source matches a pending result, r0 never forwards
	function automatic logic tag_hit(fwd_tag_t tag, reg_idx_t idx);
		return tag.valid && (tag.rd == idx) && (idx != '0);
	endfunction

	// Youngest producer wins: execute before writeback before register file
	function automatic opsel_t pick_src(reg_idx_t idx, fwd_tag_t ex_t, fwd_tag_t wb_t);
		if (tag_hit(ex_t, idx))
			return SEL_EX_FORW;
		else if (tag_hit(wb_t, idx))
			return SEL_WB_FORW;
		else
			return SEL_RF;
	endfunction

	// Only the multiplier stalls the front end
	assign instr_ready = ~freeze;

	//////////////////////////////////////////////////
	// Instruction latch
	//////////////////////////////////////////////////

	// Valid level, a dropped instr_valid becomes a bubble
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			dec_valid <= 1'b0;
		else if (!freeze)
			dec_valid <= instr_valid;
	end

	// Payload, qualified by dec_valid
	always_ff @(posedge clk) begin
		if (!freeze)
			dec_instr <= instr;
	end

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////

	assign ra_addr = dec_instr.ra;
	assign rb_addr = dec_instr.rb;

	// Immediate sign extension
	assign simm = `INT_PIPE_XLEN'($signed(dec_instr.imm));

	// Re-evaluated every cycle, so a frozen instruction picks up the
	// multiplier result on the cycle the freeze drops
	assign a_sel = pick_src(dec_instr.ra, ex_tag, wb_tag);
	assign b_sel = dec_instr.use_imm ? SEL_IMM : pick_src(dec_instr.rb, ex_tag, wb_tag);

	//////////////////////////////////////////////////
	// Decode to execute register
	//////////////////////////////////////////////////

	// Holds during freeze, otherwise takes the instruction or a bubble
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_ctrl <= '0;
		end else if (!freeze) begin
			ex_ctrl.valid <= dec_valid;
			ex_ctrl.op    <= dec_instr.op;
			ex_ctrl.rd    <= dec_instr.rd;
		end
	end

endmodule

`default_nettype wire

/* hw/operand_mux.sv */
/*
 * Forwarding multiplexers and operand registers for operands A and B
 */
`timescale 1ns/1ps
`default_nettype none

`include "int_pipe_cfg.svh"

module operand_mux (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          freeze,
	// Candidate sources
	input  wire [`INT_PIPE_XLEN-1:0]     rf_a,
	input  wire [`INT_PIPE_XLEN-1:0]     rf_b,
	input  wire [`INT_PIPE_XLEN-1:0]     ex_forw,
	input  wire [`INT_PIPE_XLEN-1:0]     wb_forw,
	input  wire [`INT_PIPE_XLEN-1:0]     simm,
	// Source selects from decode
	input  wire pipe_pkg::opsel_t        a_sel,
	input  wire pipe_pkg::opsel_t        b_sel,
	// Registered operands into execute
	output logic [`INT_PIPE_XLEN-1:0]    operand_a,
	output logic [`INT_PIPE_XLEN-1:0]    operand_b
);

	import pipe_pkg::*;

	logic [`INT_PIPE_XLEN-1:0] muxed_a;
	logic [`INT_PIPE_XLEN-1:0] muxed_b;

	//////////////////////////////////////////////////
	// Forwarding muxes
	//////////////////////////////////////////////////

	// Operand A, no immediate path
	always_comb begin
		case (a_sel)
			SEL_EX_FORW: muxed_a = ex_forw;
			SEL_WB_FORW: muxed_a = wb_forw;
			default:     muxed_a = rf_a;
		endcase
	end

	// Operand B, immediate takes priority in decode
	always_comb begin
		case (b_sel)
			SEL_IMM:     muxed_b = simm;
			SEL_EX_FORW: muxed_b = ex_forw;
			SEL_WB_FORW: muxed_b = wb_forw;
			default:     muxed_b = rf_b;
		endcase
	end

	//////////////////////////////////////////////////
	// Operand registers
	//////////////////////////////////////////////////

	// Decode and execute freeze together, one hold condition
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			operand_a <= '0;
			operand_b <= '0;
		end else if (!freeze) begin
			operand_a <= muxed_a;
			operand_b <= muxed_b;
		end
	end

endmodule

`default_nettype wire

/* hw/execute_stage.sv */
/*
 * Execute stage: ALU, multi-cycle multiplier that raises freeze,
 * and the writeback register that feeds forwarding, register file and retire
 */
`timescale 1ns/1ps
`default_nettype none

`include "int_pipe_cfg.svh"

module execute_stage (
	input  wire                          clk,
	input  wire                          rst_n,
	// From decode and the operand registers
	input  wire pipe_pkg::ex_ctrl_t      ex_ctrl,
	input  wire [`INT_PIPE_XLEN-1:0]     operand_a,
	input  wire [`INT_PIPE_XLEN-1:0]     operand_b,
	// Pipeline stall
	output logic                         freeze,
	// Forwarding sources and their tags
	output logic [`INT_PIPE_XLEN-1:0]    ex_forw,
	output logic [`INT_PIPE_XLEN-1:0]    wb_forw,
	output pipe_pkg::fwd_tag_t           ex_tag,
	output pipe_pkg::fwd_tag_t           wb_tag,
	// Retire port
	output logic                         retire_valid,
	output pipe_pkg::retire_t            retire
);

	import isa_pkg::*;
	import pipe_pkg::*;

	// Counter spans 0 .. MUL_CYCLES-1
	localparam int CNT_W   = $clog2(`INT_PIPE_MUL_CYCLES);
	// Shift amount bits
	localparam int SHAMT_W = $clog2(`INT_PIPE_XLEN);

	logic [CNT_W-1:0]          mul_cnt;
	logic                      mul_active;
	logic                      mul_last;
	logic [`INT_PIPE_XLEN-1:0] prod_q;
	logic [`INT_PIPE_XLEN-1:0] alu_res;

	//////////////////////////////////////////////////
	// Multiplier
	//////////////////////////////////////////////////

	assign mul_active = ex_ctrl.valid && (ex_ctrl.op == OP_MUL);
	assign mul_last   = (mul_cnt == CNT_W'(`INT_PIPE_MUL_CYCLES - 1));

	// High from the first multiply cycle up to, not including, the last
	assign freeze = mul_active && !mul_last;

	// Cycle count of the multiply in execute, clears when it leaves
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			mul_cnt <= '0;
		else if (freeze)
			mul_cnt <= mul_cnt + 1'b1;
		else
			mul_cnt <= '0;
	end

	// Product captured on the first cycle, operands are held meanwhile
	// Low XLEN bits only
	always_ff @(posedge clk) begin
		if (mul_active && (mul_cnt == '0))
			prod_q <= operand_a * operand_b;
	end

	//////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////

	always_comb begin
		case (ex_ctrl.op)
			OP_ADD:  alu_res = operand_a + operand_b;
			OP_SUB:  alu_res = operand_a - operand_b;
			OP_AND:  alu_res = operand_a & operand_b;
			OP_OR:   alu_res = operand_a | operand_b;
			OP_XOR:  alu_res = operand_a ^ operand_b;
			// Shifts use the low bits of B, logical right shift
			OP_SLL:  alu_res = operand_a << operand_b[SHAMT_W-1:0];
			OP_SRL:  alu_res = operand_a >> operand_b[SHAMT_W-1:0];
			// Only meaningful in the last multiply cycle
			OP_MUL:  alu_res = prod_q;
			default: alu_res = '0;
		endcase
	end

	// Execute result and its tag for forwarding
	assign ex_forw      = alu_res;
	assign ex_tag.valid = ex_ctrl.valid;
	assign ex_tag.rd    = ex_ctrl.rd;

	//////////////////////////////////////////////////
	// Writeback register
	//////////////////////////////////////////////////

	// Bubble during freeze so a multiply retires once
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wb_tag <= '0;
		else if (freeze)
			wb_tag.valid <= 1'b0;
		else
			wb_tag <= ex_tag;
	end

	always_ff @(posedge clk) begin
		if (!freeze)
			wb_forw <= ex_forw;
	end

	// One-cycle strobe per result, in program order
	assign retire_valid = wb_tag.valid;
	assign retire.rd    = wb_tag.rd;
	assign retire.data  = wb_forw;

endmodule

`default_nettype wire

/* hw/int_pipe_top.sv */
/*
 * Integer pipeline slice top: decode, operand mux, execute and register file
 */
`timescale 1ns/1ps
`default_nettype none

`include "int_pipe_cfg.svh"

module int_pipe_top (
	input  wire                      clk,
	input  wire                      rst_n,
	// Instruction stream
	input  wire isa_pkg::instr_t     instr,
	input  wire                      instr_valid,
	output logic                     instr_ready,
	// Retired results
	output logic                     retire_valid,
	output pipe_pkg::retire_t        retire
);

	import isa_pkg::*;
	import pipe_pkg::*;

	// Decode outputs
	reg_idx_t                  ra_addr;
	reg_idx_t                  rb_addr;
	logic [`INT_PIPE_XLEN-1:0] simm;
	opsel_t                    a_sel;
	opsel_t                    b_sel;
	ex_ctrl_t                  ex_ctrl;

	// Register file reads
	logic [`INT_PIPE_XLEN-1:0] rf_a;
	logic [`INT_PIPE_XLEN-1:0] rf_b;

	// Execute operands
	logic [`INT_PIPE_XLEN-1:0] operand_a;
	logic [`INT_PIPE_XLEN-1:0] operand_b;

	// Execute outputs, writeback doubles as register file write port
	logic                      freeze;
	logic [`INT_PIPE_XLEN-1:0] ex_forw;
	logic [`INT_PIPE_XLEN-1:0] wb_forw;
	fwd_tag_t                  ex_tag;
	fwd_tag_t                  wb_tag;

	decode_stage u_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr       (instr),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.freeze      (freeze),
		.ex_tag      (ex_tag),
		.wb_tag      (wb_tag),
		.ra_addr     (ra_addr),
		.rb_addr     (rb_addr),
		.simm        (simm),
		.a_sel       (a_sel),
		.b_sel       (b_sel),
		.ex_ctrl     (ex_ctrl)
	);

	reg_file u_rf (
		.clk     (clk),
		.rst_n   (rst_n),
		.ra_addr (ra_addr),
		.rb_addr (rb_addr),
		.rf_a    (rf_a),
		.rf_b    (rf_b),
		.wr_tag  (wb_tag),
		.wr_data (wb_forw)
	);

	operand_mux u_opmux (
		.clk       (clk),
		.rst_n     (rst_n),
		.freeze    (freeze),
		.rf_a      (rf_a),
		.rf_b      (rf_b),
		.ex_forw   (ex_forw),
		.wb_forw   (wb_forw),
		.simm      (simm),
		.a_sel     (a_sel),
		.b_sel     (b_sel),
		.operand_a (operand_a),
		.operand_b (operand_b)
	);

	execute_stage u_exec (
		.clk          (clk),
		.rst_n        (rst_n),
		.ex_ctrl      (ex_ctrl),
		.operand_a    (operand_a),
		.operand_b    (operand_b),
		.freeze       (freeze),
		.ex_forw      (ex_forw),
		.wb_forw      (wb_forw),
		.ex_tag       (ex_tag),
		.wb_tag       (wb_tag),
		.retire_valid (retire_valid),
		.retire       (retire)
	);

endmodule

`default_nettype wire

/* bench/int_pipe_tb.sv */
/*
 * Integer pipeline slice testbench with clock, reset, directed and random
 * instruction stream, architectural reference model and retire checks
 */
`timescale 1ns/1ps
`default_nettype none

`include "int_pipe_cfg.svh"

module int_pipe_tb;

	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int XLEN       = `INT_PIPE_XLEN;
	localparam int NREGS      = `INT_PIPE_NREGS;
	localparam int MUL_CYCLES = `INT_PIPE_MUL_CYCLES;
	localparam int NUM_RANDOM = 2000;
	// Cycle budget for any single wait
	localparam int WAIT_LIMIT = 50;

	logic    clk;
	logic    rst_n;
	instr_t  instr;
	logic    instr_valid;
	logic    instr_ready;
	logic    retire_valid;
	retire_t retire;

	integer seed;

	// Architectural state and the results still owed by the DUT
	logic [XLEN-1:0] arch_regs [NREGS];
	retire_t         exp_q [$];

	int_pipe_top dut0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr        (instr),
		.instr_valid  (instr_valid),
		.instr_ready  (instr_ready),
		.retire_valid (retire_valid),
		.retire       (retire)
	);

	// 8 ns period
	always #4 clk = ~clk;

	//////////////////////////////////////////////////
	// Reporting
	//////////////////////////////////////////////////

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check_eq(input string what, input logic [XLEN-1:0] got,
			input logic [XLEN-1:0] exp);
		if (got !== exp)
			stop_run($sformatf("MISMATCH at %0t ns: %s got 0x%h, expected 0x%h",
				$time, what, got, exp));
	endtask

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Result by the ISA rules against architectural state
	function automatic logic [XLEN-1:0] model_result(input instr_t ins);
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		a = arch_regs[ins.ra];
		b = ins.use_imm ? {{(XLEN-16){ins.imm[15]}}, ins.imm} : arch_regs[ins.rb];
		case (ins.op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_SLL:  return a << b[4:0];
			OP_SRL:  return a >> b[4:0];
			default: return a * b;
		endcase
	endfunction

	// Expected retire queued in program order
	// r0 stays zero in the model
	task automatic model_accept(input instr_t ins);
		retire_t r;
		r.rd   = ins.rd;
		r.data = model_result(ins);
		exp_q.push_back(r);
		if (ins.rd != '0)
			arch_regs[ins.rd] = r.data;
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	function automatic instr_t make_instr(input op_t op, input logic use_imm,
			input reg_idx_t rd, input reg_idx_t ra, input reg_idx_t rb,
			input logic [15:0] imm);
		instr_t ins;
		ins.op      = op;
		ins.use_imm = use_imm;
		ins.rd      = rd;
		ins.ra      = ra;
		ins.rb      = rb;
		ins.imm     = imm;
		return ins;
	endfunction

	// Mostly r0..r3 so that dependencies are close together
	function automatic reg_idx_t rand_idx();
		logic [31:0] r;
		r = $random(seed);
		if (r[7:5] != 3'd0)
			return reg_idx_t'(r[1:0]);
		else
			return reg_idx_t'(r[3:0]);
	endfunction

	function automatic instr_t rand_instr();
		logic [31:0] r;
		r = $random(seed);
		return make_instr(op_t'(r[2:0]), r[3], rand_idx(), rand_idx(), rand_idx(), r[31:16]);
	endfunction

	// Called 1 ns after a rising edge and returns 1 ns after the accepting edge
	// instr_valid is left high for back-to-back issue
	task automatic issue(input instr_t ins);
		int waited;
		waited      = 0;
		instr       = ins;
		instr_valid = 1'b1;
		@(negedge clk);
		while (!instr_ready) begin
			waited++;
			if (waited > WAIT_LIMIT)
				stop_run("Timeout: instr_ready stayed low while an instruction was waiting");
			else
				@(negedge clk);
		end
		@(posedge clk);
		model_accept(ins);
		#1;
	endtask

	// Bubbles with a random payload behind a low valid
	task automatic idle(input int cycles);
		instr_valid = 1'b0;
		instr       = rand_instr();
		repeat (cycles) begin
			@(posedge clk);
			#1;
		end
	endtask

	//////////////////////////////////////////////////
	// Retire checker
	//////////////////////////////////////////////////

	// Outputs settle after the rising edge and are sampled mid-cycle
	always @(negedge clk) begin : retire_check
		retire_t expected;
		if (rst_n && retire_valid) begin
			if (exp_q.size() == 0) begin
				stop_run("A result retired although no accepted instruction was left");
			end else begin
				expected = exp_q.pop_front();
				check_eq("retire rd", XLEN'(retire.rd), XLEN'(expected.rd));
				check_eq("retire data", retire.data, expected.data);
			end
		end
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		int waited;
		seed         = 32'h4259_3695;
		clk          = 1'b0;
		rst_n        = 1'b0;
		instr        = '0;
		instr_valid  = 1'b0;
		for (int i = 0; i < NREGS; i++)
			arch_regs[i] = '0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Idle state after reset
		@(negedge clk);
		check_eq("instr_ready after reset", XLEN'(instr_ready), 1);
		check_eq("retire_valid after reset", XLEN'(retire_valid), 0);
		@(posedge clk);
		#1;

		// Every register reads zero when added to r0
		for (int i = 0; i < NREGS; i++)
			issue(make_instr(OP_ADD, 1'b0, reg_idx_t'(i), reg_idx_t'(i), '0, '0));

		// All opcodes with register B and then immediate B
		issue(make_instr(OP_ADD, 1'b1, 4'd5, 4'd0, 4'd0, 16'h1234));
		issue(make_instr(OP_ADD, 1'b1, 4'd6, 4'd0, 4'd0, 16'hfff3));
		for (int op = 0; op < 8; op++) begin
			issue(make_instr(op_t'(op), 1'b0, 4'd7, 4'd5, 4'd6, 16'h0000));
			issue(make_instr(op_t'(op), 1'b1, 4'd7, 4'd5, 4'd6, 16'h8005));
		end

		// Consumers at distance 1, 2 and 3 from one producer
		issue(make_instr(OP_ADD, 1'b1, 4'd1, 4'd0, 4'd0, 16'h0007));
		issue(make_instr(OP_ADD, 1'b0, 4'd2, 4'd1, 4'd1, 16'h0000));
		issue(make_instr(OP_SUB, 1'b0, 4'd3, 4'd0, 4'd1, 16'h0000));
		issue(make_instr(OP_XOR, 1'b0, 4'd4, 4'd1, 4'd5, 16'h0000));

		// r0 writes retire their data while later reads still see zero
		issue(make_instr(OP_ADD, 1'b1, 4'd0, 4'd5, 4'd0, 16'h0042));
		issue(make_instr(OP_OR, 1'b0, 4'd8, 4'd0, 4'd0, 16'h0000));
		issue(make_instr(OP_ADD, 1'b0, 4'd9, 4'd0, 4'd5, 16'h0000));

		// Multiply from an empty pipe with a dependent follower right behind it
		idle(6);
		issue(make_instr(OP_MUL, 1'b0, 4'd1, 4'd5, 4'd6, 16'h0000));
		issue(make_instr(OP_ADD, 1'b0, 4'd2, 4'd1, 4'd5, 16'h0000));
		instr_valid = 1'b0;
		// Low from the cycle after the multiply was accepted, then high again
		for (int k = 0; k < MUL_CYCLES + 3; k++) begin
			@(negedge clk);
			check_eq("instr_ready after multiply", XLEN'(instr_ready),
				XLEN'(k >= MUL_CYCLES - 1));
		end
		@(posedge clk);
		#1;
		// Product used two slots later
		issue(make_instr(OP_MUL, 1'b1, 4'd3, 4'd1, 4'd0, 16'hfffd));
		issue(make_instr(OP_ADD, 1'b1, 4'd4, 4'd0, 4'd0, 16'h0001));
		issue(make_instr(OP_XOR, 1'b0, 4'd4, 4'd3, 4'd2, 16'h0000));

		// Random stream with dropped valid
		for (int n = 0; n < NUM_RANDOM; n++) begin
			if (({$random(seed)} % 4) == 0)
				idle(int'(1 + {$random(seed)} % 3));
			issue(rand_instr());
		end
		idle(1);

		// Everything accepted must come out
		waited = 0;
		while (exp_q.size() != 0) begin
			waited++;
			if (waited > WAIT_LIMIT)
				stop_run("Timeout: the pipeline did not retire all accepted instructions");
			else
				@(negedge clk);
		end
		// Any late retire finds the queue empty
		idle(5);

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* int_pipe_top.f */
+incdir+include
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/operand_mux.sv
hw/execute_stage.sv
hw/int_pipe_top.sv
bench/int_pipe_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the integer pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	-f int_pipe_top.f \
	--top-module int_pipe_tb \
	-o int_pipe_sim

# Result is taken from the printed output
sim_out=$(./obj_dir/int_pipe_sim 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q '^>>> PASS$'; then
	exit 0
fi
exit 1
